//--- serv_defs.svh
`ifndef SERV_DEFS_SVH
`define SERV_DEFS_SVH

// Address of the first instruction fetch
`define SERV_RESET_PC 32'h0000_0000

// Data width, which is also the length of one serial phase
`define SERV_XLEN 32

// Bit counter width, log2 of the data width
`define SERV_CNT_W 5

// Number of integer registers, x0 included
`define SERV_NREGS 32

`endif

//--- serv_pkg.sv
package serv_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // NOP also covers every opcode the core does not implement
   typedef enum logic [2:0] {
      OP_ALU,
      OP_LOAD,
      OP_STORE,
      OP_BRANCH,
      OP_JAL,
      OP_NOP
   } op_class_e;

   typedef enum logic [1:0] {
      RD_ALU,
      RD_MEM,
      RD_LINK
   } rd_src_e;

   typedef struct packed {
      op_class_e  op_class;
      alu_op_e    alu_op;
      logic       use_imm;
      rd_src_e    rd_src;
      logic       rd_wen;
      logic       branch_ne;
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
   } dec_t;

endpackage

//--- serv_cnt_if.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

interface serv_cnt_if;

   // Index of the bit that is on the serial lines this cycle
   logic [`SERV_CNT_W-1:0] cnt;
   logic                   cnt_en;
   logic                   init;
   logic                   run;
   // Last bit of an init or run phase
   logic                   cnt_done;

   modport seq (
      output cnt,
      output cnt_en,
      output init,
      output run,
      output cnt_done
   );

   modport dp (
      input cnt,
      input cnt_en,
      input init,
      input run,
      input cnt_done
   );

endinterface

//--- serv_state.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_state (
   input  logic           clk,
   input  logic           i_rst,
   serv_cnt_if.seq        cnt,
   input  logic           i_ibus_ack,
   input  logic           i_dbus_ack,
   input  serv_pkg::dec_t i_dec,
   output logic           o_fetch,
   output logic           o_dbus_cyc
);
   import serv_pkg::*;

   // Decode happens on the fetch acknowledge edge, so S_FIRST already sees
   // a valid instruction and acts as init or run depending on its class
   typedef enum logic [1:0] {
      S_FETCH,
      S_FIRST,
      S_MEM,
      S_LAST
   } state_e;

   state_e                 state;
   state_e                 state_nxt;
   logic [`SERV_CNT_W-1:0] cnt_q;
   logic                   mem_op;
   logic                   two_phase;
   logic                   phase;
   logic                   done;

   assign mem_op    = (i_dec.op_class == OP_LOAD) || (i_dec.op_class == OP_STORE);
   assign two_phase = mem_op || (i_dec.op_class == OP_BRANCH);
   assign phase     = (state == S_FIRST) || (state == S_LAST);
   assign done      = phase && (cnt_q == `SERV_CNT_W'(`SERV_XLEN - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         S_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = S_FIRST;
            end
         end
         S_FIRST: begin
            if (done) begin
               if (!two_phase) begin
                  state_nxt = S_FETCH;
               end else begin
                  state_nxt = mem_op ? S_MEM : S_LAST;
               end
            end
         end
         S_MEM: begin
            if (i_dbus_ack) begin
               state_nxt = S_LAST;
            end
         end
         default: begin
            if (done) begin
               state_nxt = S_FETCH;
            end
         end
      endcase
   end

   // Counter wraps back to zero at the end of every phase
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= S_FETCH;
         cnt_q <= '0;
      end else begin
         state <= state_nxt;
         if (phase) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   assign cnt.cnt      = cnt_q;
   assign cnt.cnt_en   = phase;
   assign cnt.init     = (state == S_FIRST) && two_phase;
   assign cnt.run      = ((state == S_FIRST) && !two_phase) || (state == S_LAST);
   assign cnt.cnt_done = done;

   assign o_fetch    = (state == S_FETCH);
   assign o_dbus_cyc = (state == S_MEM);

endmodule

//--- serv_decode.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_decode (
   input  logic                  clk,
   input  logic                  i_ibus_ack,
   input  logic [`SERV_XLEN-1:0] i_ibus_rdt,
   serv_cnt_if.dp                cnt,
   output serv_pkg::dec_t        o_dec,
   output logic                  o_imm
);
   import serv_pkg::*;

   logic [`SERV_XLEN-1:0] instr;
   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic                  bool_f3;
   alu_op_e               f3_op;
   logic [`SERV_XLEN-1:0] imm_i;
   logic [`SERV_XLEN-1:0] imm_s;
   logic [`SERV_XLEN-1:0] imm_b;
   logic [`SERV_XLEN-1:0] imm_j;
   logic [`SERV_XLEN-1:0] imm_word;
   dec_t                  dec;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr <= i_ibus_rdt;
      end
   end

   assign opcode  = instr[6:0];
   assign funct3  = instr[14:12];
   assign funct7  = instr[31:25];
   assign bool_f3 = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};

   always_comb begin
      case (funct3)
         3'b100:  f3_op = ALU_XOR;
         3'b110:  f3_op = ALU_OR;
         3'b111:  f3_op = ALU_AND;
         default: f3_op = ALU_ADD;
      endcase
   end

   always_comb begin
      dec.op_class  = OP_NOP;
      dec.alu_op    = ALU_ADD;
      dec.use_imm   = 1'b0;
      dec.rd_src    = RD_ALU;
      dec.branch_ne = funct3[0];
      dec.rd_addr   = instr[11:7];
      dec.rs1_addr  = instr[19:15];
      dec.rs2_addr  = instr[24:20];
      case (opcode)
         7'b0010011: begin
            if (bool_f3) begin
               dec.op_class = OP_ALU;
               dec.alu_op   = f3_op;
               dec.use_imm  = 1'b1;
            end
         end
         7'b0110011: begin
            if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
               dec.op_class = OP_ALU;
               dec.alu_op   = ALU_SUB;
            end else if (funct7 == 7'b0000000 && bool_f3) begin
               dec.op_class = OP_ALU;
               dec.alu_op   = f3_op;
            end
         end
         7'b0000011: begin
            if (funct3 == 3'b010) begin
               dec.op_class = OP_LOAD;
               dec.use_imm  = 1'b1;
               dec.rd_src   = RD_MEM;
            end
         end
         7'b0100011: begin
            if (funct3 == 3'b010) begin
               dec.op_class = OP_STORE;
               dec.use_imm  = 1'b1;
            end
         end
         7'b1100011: begin
            // Only BEQ and BNE
            if (funct3[2:1] == 2'b00) begin
               dec.op_class = OP_BRANCH;
            end
         end
         7'b1101111: begin
            dec.op_class = OP_JAL;
            dec.rd_src   = RD_LINK;
         end
         default: begin
         end
      endcase
      dec.rd_wen = (dec.op_class inside {OP_ALU, OP_LOAD, OP_JAL}) && (instr[11:7] != 5'd0);
   end

   assign o_dec = dec;

   // Immediates rebuilt sign extended, then read out one bit per count
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (dec.op_class)
         OP_STORE:  imm_word = imm_s;
         OP_BRANCH: imm_word = imm_b;
         OP_JAL:    imm_word = imm_j;
         default:   imm_word = imm_i;
      endcase
   end

   assign o_imm = imm_word[cnt.cnt];

endmodule

//--- serv_alu.sv
`timescale 1ns/1ps

module serv_alu (
   input  logic              clk,
   serv_cnt_if.dp            cnt,
   input  serv_pkg::alu_op_e i_op,
   input  logic              i_rs1,
   input  logic              i_op_b,
   output logic              o_rd,
   output logic              o_eq
);
   import serv_pkg::*;

   logic sub;
   logic first;
   logic b_in;
   logic cin;
   logic carry;
   logic sum;
   logic same;
   logic eq_acc;

   assign sub   = (i_op == ALU_SUB);
   assign first = (cnt.cnt == '0);
   assign b_in  = i_op_b ^ sub;

   // Subtraction is a plus inverted b plus one, the one enters as carry on bit 0
   assign cin  = first ? sub : carry;
   assign sum  = i_rs1 ^ b_in ^ cin;
   assign same = ~(i_rs1 ^ i_op_b);

   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         carry <= (i_rs1 & b_in) | (i_rs1 & cin) | (b_in & cin);
      end
      // Equality of rs1 and rs2 builds up over the init phase of a branch
      if (cnt.init) begin
         eq_acc <= same & (first | eq_acc);
      end
   end

   always_comb begin
      case (i_op)
         ALU_AND: o_rd = i_rs1 & i_op_b;
         ALU_OR:  o_rd = i_rs1 | i_op_b;
         ALU_XOR: o_rd = i_rs1 ^ i_op_b;
         default: o_rd = sum;
      endcase
   end

   assign o_eq = eq_acc;

endmodule

//--- serv_rf.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_rf (
   input  logic       clk,
   serv_cnt_if.dp     cnt,
   input  logic [4:0] i_rs1_addr,
   input  logic [4:0] i_rs2_addr,
   input  logic [4:0] i_rd_addr,
   input  logic       i_rd_wen,
   input  logic       i_rd,
   output logic       o_rs1,
   output logic       o_rs2
);

   logic [`SERV_XLEN-1:0] regs [`SERV_NREGS];
   // Holds rd bits 0 to 30, the last bit joins them on the commit cycle
   logic [`SERV_XLEN-2:0] wbuf;

   assign o_rs1 = (i_rs1_addr != 5'd0) & regs[i_rs1_addr][cnt.cnt];
   assign o_rs2 = (i_rs2_addr != 5'd0) & regs[i_rs2_addr][cnt.cnt];

   always_ff @(posedge clk) begin
      if (cnt.run) begin
         wbuf <= {i_rd, wbuf[`SERV_XLEN-2:1]};
      end
      // Whole word written at once so rs reads stay clean during run
      if (cnt.run && cnt.cnt_done && i_rd_wen) begin
         regs[i_rd_addr] <= {i_rd, wbuf};
      end
   end

endmodule

//--- serv_ctrl.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_ctrl (
   input  logic                  clk,
   input  logic                  i_rst,
   serv_cnt_if.dp                cnt,
   input  logic                  i_fetch,
   input  logic                  i_jump,
   input  logic                  i_imm,
   output logic                  o_link,
   output logic [`SERV_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc
);

   logic [`SERV_XLEN-1:0] pc;
   logic                  first;
   logic                  four_bit;
   logic                  inc_cin;
   logic                  inc_carry;
   logic                  inc_bit;
   logic                  tgt_cin;
   logic                  tgt_carry;
   logic                  tgt_bit;
   logic                  new_bit;

   assign first    = (cnt.cnt == '0);
   assign four_bit = (cnt.cnt == `SERV_CNT_W'(2));
   assign inc_cin  = first ? 1'b0 : inc_carry;
   assign tgt_cin  = first ? 1'b0 : tgt_carry;
   assign inc_bit  = pc[0] ^ four_bit ^ inc_cin;
   assign tgt_bit  = pc[0] ^ i_imm ^ tgt_cin;
   assign new_bit  = i_jump ? tgt_bit : inc_bit;

   // PC rotates right through bit 0 during run, so it holds the new
   // address once the last bit is in at cnt_done
   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc <= `SERV_RESET_PC;
      end else if (cnt.run) begin
         pc <= {new_bit, pc[`SERV_XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (cnt.run) begin
         inc_carry <= (pc[0] & four_bit) | (pc[0] & inc_cin) | (four_bit & inc_cin);
         tgt_carry <= (pc[0] & i_imm) | (pc[0] & tgt_cin) | (i_imm & tgt_cin);
      end
   end

   assign o_link     = inc_bit;
   assign o_ibus_adr = pc;
   assign o_ibus_cyc = i_fetch;

endmodule

//--- serv_mem_if.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_mem_if (
   input  logic                  clk,
   serv_cnt_if.dp                cnt,
   input  logic                  i_is_store,
   input  logic                  i_addr_bit,
   input  logic                  i_rs2,
   input  logic                  i_dbus_ack,
   input  logic [`SERV_XLEN-1:0] i_dbus_rdt,
   output logic                  o_rd,
   output logic [`SERV_XLEN-1:0] o_dbus_adr,
   output logic [`SERV_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_we
);

   // Word aligned only, bits 1:0 fall off the end of the shift
   logic [`SERV_XLEN-3:0] adr_buf;
   logic [`SERV_XLEN-1:0] dat_buf;
   logic [`SERV_XLEN-1:0] rdat;

   always_ff @(posedge clk) begin
      if (cnt.init) begin
         adr_buf <= {i_addr_bit, adr_buf[`SERV_XLEN-3:1]};
         if (i_is_store) begin
            dat_buf <= {i_rs2, dat_buf[`SERV_XLEN-1:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_dbus_ack) begin
         rdat <= i_dbus_rdt;
      end else if (cnt.run) begin
         rdat <= {1'b0, rdat[`SERV_XLEN-1:1]};
      end
   end

   assign o_rd       = rdat[0];
   assign o_dbus_adr = {adr_buf, 2'b00};
   assign o_dbus_dat = dat_buf;
   assign o_dbus_we  = i_is_store;

endmodule

//--- serv_top.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_top (
   input  logic                  clk,
   input  logic                  i_rst,
   output logic [`SERV_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc,
   input  logic [`SERV_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_ibus_ack,
   output logic [`SERV_XLEN-1:0] o_dbus_adr,
   output logic [`SERV_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_we,
   output logic                  o_dbus_cyc,
   input  logic [`SERV_XLEN-1:0] i_dbus_rdt,
   input  logic                  i_dbus_ack
);
   import serv_pkg::*;

   dec_t dec;
   logic fetch;
   logic imm;
   logic rs1;
   logic rs2;
   logic op_b;
   logic alu_rd;
   logic alu_eq;
   logic mem_rd;
   logic link;
   logic rd;
   logic jump;
   logic is_store;

   serv_cnt_if cnt_bus ();

   assign op_b     = dec.use_imm ? imm : rs2;
   assign is_store = (dec.op_class == OP_STORE);

   // Branch outcome is settled by the end of init, before the PC moves
   assign jump = (dec.op_class == OP_JAL) ||
                 ((dec.op_class == OP_BRANCH) && (alu_eq ^ dec.branch_ne));

   always_comb begin
      case (dec.rd_src)
         RD_MEM:  rd = mem_rd;
         RD_LINK: rd = link;
         default: rd = alu_rd;
      endcase
   end

   serv_state state (
      .clk        (clk),
      .i_rst      (i_rst),
      .cnt        (cnt_bus.seq),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_dec      (dec),
      .o_fetch    (fetch),
      .o_dbus_cyc (o_dbus_cyc)
   );

   serv_decode decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .cnt        (cnt_bus.dp),
      .o_dec      (dec),
      .o_imm      (imm)
   );

   serv_alu alu (
      .clk    (clk),
      .cnt    (cnt_bus.dp),
      .i_op   (dec.alu_op),
      .i_rs1  (rs1),
      .i_op_b (op_b),
      .o_rd   (alu_rd),
      .o_eq   (alu_eq)
   );

   serv_rf regfile (
      .clk        (clk),
      .cnt        (cnt_bus.dp),
      .i_rs1_addr (dec.rs1_addr),
      .i_rs2_addr (dec.rs2_addr),
      .i_rd_addr  (dec.rd_addr),
      .i_rd_wen   (dec.rd_wen),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_ctrl ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .cnt        (cnt_bus.dp),
      .i_fetch    (fetch),
      .i_jump     (jump),
      .i_imm      (imm),
      .o_link     (link),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc)
   );

   // The ALU sum during init is the load or store address
   serv_mem_if mem_if (
      .clk        (clk),
      .cnt        (cnt_bus.dp),
      .i_is_store (is_store),
      .i_addr_bit (alu_rd),
      .i_rs2      (rs2),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .o_rd       (mem_rd),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we)
   );

endmodule

//--- tb_serv_mem.sv
`timescale 1ns/1ps

module tb_serv_mem (
   input  logic        clk,
   input  logic        i_rst,
   input  logic [31:0] i_image [256],
   input  logic [31:0] i_ibus_adr,
   input  logic        i_ibus_cyc,
   output logic [31:0] o_ibus_rdt,
   output logic        o_ibus_ack,
   input  logic [31:0] i_dbus_adr,
   input  logic [31:0] i_dbus_dat,
   input  logic        i_dbus_we,
   input  logic        i_dbus_cyc,
   output logic [31:0] o_dbus_rdt,
   output logic        o_dbus_ack,
   output logic        o_wr_en,
   output logic [31:0] o_wr_adr,
   output logic [31:0] o_wr_dat
);

   logic [31:0] mem [256];
   logic        in_rst;
   logic        ibus_busy;
   logic        dbus_busy;
   int          ibus_wait;
   int          dbus_wait;
   int          idx;

   // Delay of 0 to 3 cycles is picked when a request first shows up
   task automatic serve_ibus();
      if (i_ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            ibus_wait = $urandom % 4;
         end
         if (ibus_wait == 0) begin
            o_ibus_ack = 1'b1;
            o_ibus_rdt = mem[i_ibus_adr[9:2]];
            ibus_busy  = 1'b0;
         end else begin
            ibus_wait = ibus_wait - 1;
         end
      end
   endtask

   task automatic serve_dbus();
      if (i_dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_wait = $urandom % 4;
         end
         if (dbus_wait == 0) begin
            o_dbus_ack = 1'b1;
            dbus_busy  = 1'b0;
            if (i_dbus_we) begin
               mem[i_dbus_adr[9:2]] = i_dbus_dat;
               o_wr_en  = 1'b1;
               o_wr_adr = i_dbus_adr;
               o_wr_dat = i_dbus_dat;
            end else begin
               o_dbus_rdt = mem[i_dbus_adr[9:2]];
            end
         end else begin
            dbus_wait = dbus_wait - 1;
         end
      end
   endtask

   initial begin
      void'($urandom(32'ha390fc5e));
      o_ibus_rdt = '0;
      o_ibus_ack = 1'b0;
      o_dbus_rdt = '0;
      o_dbus_ack = 1'b0;
      o_wr_en    = 1'b0;
      o_wr_adr   = '0;
      o_wr_dat   = '0;
      ibus_busy  = 1'b0;
      dbus_busy  = 1'b0;
      ibus_wait  = 0;
      dbus_wait  = 0;
      forever begin
         @(posedge clk);
         in_rst = i_rst;
         #1;
         o_ibus_ack = 1'b0;
         o_dbus_ack = 1'b0;
         o_wr_en    = 1'b0;
         if (in_rst) begin
            // Image is reloaded while the core sits in reset
            for (idx = 0; idx < 256; idx++) begin
               mem[idx] = i_image[idx];
            end
            ibus_busy = 1'b0;
            dbus_busy = 1'b0;
         end else begin
            serve_ibus();
            serve_dbus();
         end
      end
   end

endmodule

//--- tb_serv.sv
`timescale 1ns/1ps
`include "serv_defs.svh"

module tb_serv;

   // About 40 instructions at up to 150 cycles each, with wide margin
   localparam int MAX_CYCLES  = 20000;
   localparam int IDLE_CYCLES = 300;

   localparam logic [6:0]  OPC_IMM    = 7'b0010011;
   localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
   localparam logic [31:0] PRELOAD_ADR = 32'h0000_03F0;
   localparam logic [31:0] PRELOAD_VAL = 32'hA5C3_0F96;

   logic        clk;
   logic        rst;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;
   logic        wr_en;
   logic [31:0] wr_adr;
   logic [31:0] wr_dat;

   logic [31:0] image [256];
   logic [31:0] exp_adr [32];
   logic [31:0] exp_dat [32];
   logic [31:0] pc_b;
   logic [31:0] park_pc;
   int          n_exp;
   int          n_seen;
   int          cycles;

   serv_top dut0 (
      .clk        (clk),
      .i_rst      (rst),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   tb_serv_mem mem0 (
      .clk        (clk),
      .i_rst      (rst),
      .i_image    (image),
      .i_ibus_adr (ibus_adr),
      .i_ibus_cyc (ibus_cyc),
      .o_ibus_rdt (ibus_rdt),
      .o_ibus_ack (ibus_ack),
      .i_dbus_adr (dbus_adr),
      .i_dbus_dat (dbus_dat),
      .i_dbus_we  (dbus_we),
      .i_dbus_cyc (dbus_cyc),
      .o_dbus_rdt (dbus_rdt),
      .o_dbus_ack (dbus_ack),
      .o_wr_en    (wr_en),
      .o_wr_adr   (wr_adr),
      .o_wr_dat   (wr_dat)
   );

   task automatic fail_stop();
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic mismatch(input string msg);
      $display("FAILED at %0d ns: %s", $time, msg);
      fail_stop();
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      fail_stop();
   endtask

   // RV32 instruction formats
   function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   task automatic emit(input logic [31:0] instr);
      image[pc_b[9:2]] = instr;
      pc_b = pc_b + 32'd4;
   endtask

   // SW with x0 as base, so the address is the offset itself
   task automatic store_word(input logic [4:0] rs2, input logic [11:0] off,
                             input logic [31:0] value);
      emit(stype(rs2, 5'd0, off));
      exp_adr[n_exp] = sext12(off);
      exp_dat[n_exp] = value;
      n_exp = n_exp + 1;
   endtask

   task automatic build_program();
      logic [11:0] imm_a;
      logic [11:0] imm_b;
      logic [11:0] imm_c;
      logic [11:0] imm_d;
      logic [31:0] x1;
      logic [31:0] x2;
      logic [31:0] x5;
      logic [31:0] x6;
      logic [31:0] link;
      int          i;
      for (i = 0; i < 256; i++) begin
         image[i] = {16'hBAD0, 6'd0, i[7:0], 2'b00};
      end
      image[PRELOAD_ADR[9:2]] = PRELOAD_VAL;
      imm_a = -12'sd7;
      imm_b = 12'sd100;
      imm_c = 12'sd1701;
      imm_d = -12'sd60;
      x1 = sext12(imm_a);
      x2 = sext12(imm_b);
      x5 = sext12(imm_c);
      x6 = sext12(imm_d);
      pc_b  = `SERV_RESET_PC;
      n_exp = 0;
      emit(itype(OPC_IMM, 3'b000, 5'd1, 5'd0, imm_a));
      emit(itype(OPC_IMM, 3'b000, 5'd2, 5'd0, imm_b));
      emit(rtype(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
      emit(rtype(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
      store_word(5'd1, 12'h200, x1);
      store_word(5'd2, 12'h204, x2);
      store_word(5'd3, 12'h208, x1 + x2);
      store_word(5'd4, 12'h20C, x1 - x2);
      emit(itype(OPC_IMM, 3'b000, 5'd5, 5'd0, imm_c));
      emit(itype(OPC_IMM, 3'b000, 5'd6, 5'd0, imm_d));
      emit(rtype(7'b0000000, 3'b111, 5'd7, 5'd5, 5'd6));
      emit(rtype(7'b0000000, 3'b110, 5'd8, 5'd5, 5'd6));
      emit(rtype(7'b0000000, 3'b100, 5'd9, 5'd5, 5'd6));
      store_word(5'd7, 12'h210, x5 & x6);
      store_word(5'd8, 12'h214, x5 | x6);
      store_word(5'd9, 12'h218, x5 ^ x6);
      emit(itype(OPC_LOAD, 3'b010, 5'd10, 5'd0, PRELOAD_ADR[11:0]));
      store_word(5'd10, 12'h21C, PRELOAD_VAL);
      // Write to x0 must not stick
      emit(itype(OPC_IMM, 3'b000, 5'd0, 5'd0, 12'sd123));
      store_word(5'd0, 12'h220, 32'd0);
      // Taken BEQ jumps over a marker store, not-taken BNE falls into one
      emit(btype(3'b000, 5'd5, 5'd5, 13'd8));
      emit(stype(5'd2, 5'd0, 12'h224));
      emit(btype(3'b001, 5'd5, 5'd5, 13'd8));
      store_word(5'd2, 12'h228, x2);
      // Unequal operands, so this BEQ falls through
      emit(btype(3'b000, 5'd5, 5'd6, 13'd8));
      store_word(5'd6, 12'h234, x6);
      link = pc_b + 32'd4;
      emit(jtype(5'd11, 21'd8));
      emit(stype(5'd2, 5'd0, 12'h22C));
      store_word(5'd11, 12'h230, link);
      park_pc = pc_b;
      emit(jtype(5'd0, 21'd0));
   endtask

   // Sampled on the falling edge, where bus signals are settled
   ibus_hold: assert property (@(negedge clk) disable iff (rst)
      (ibus_cyc && !ibus_ack) |=> (ibus_cyc && $stable(ibus_adr)))
      else mismatch("instruction request dropped or address moved while pending");

   dbus_hold: assert property (@(negedge clk) disable iff (rst)
      (dbus_cyc && !dbus_ack) |=>
      (dbus_cyc && $stable(dbus_adr) && $stable(dbus_dat) && $stable(dbus_we)))
      else mismatch("data request dropped or address, data or we moved while pending");

   always @(posedge clk) begin
      if (wr_en) begin
         if (n_seen >= n_exp) begin
            mismatch($sformatf("unexpected store of %h to %h", wr_dat, wr_adr));
         end else begin
            store_adr: assert (wr_adr == exp_adr[n_seen])
               else mismatch($sformatf("store %0d to %h, expected address %h",
                                       n_seen, wr_adr, exp_adr[n_seen]));
            store_dat: assert (wr_dat == exp_dat[n_seen])
               else mismatch($sformatf("store %0d to %h wrote %h, expected %h",
                                       n_seen, wr_adr, wr_dat, exp_dat[n_seen]));
            n_seen = n_seen + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         abort_run($sformatf("Timeout after %0d cycles with %0d of %0d stores done",
                             MAX_CYCLES, n_seen, n_exp));
      end
   end

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   initial begin
      rst    = 1'b1;
      n_seen = 0;
      cycles = 0;
      build_program();
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      reset_fetch: assert (ibus_cyc === 1'b1 && ibus_adr === `SERV_RESET_PC)
         else mismatch("first fetch after reset is not at the reset address");
      reset_dbus: assert (dbus_cyc === 1'b0)
         else mismatch("data request active right after reset");
      wait (n_seen == n_exp);
      // Watch a while longer so that a stray store would still show up
      repeat (IDLE_CYCLES) @(posedge clk);
      @(negedge clk);
      while (!ibus_cyc) begin
         @(negedge clk);
      end
      park_fetch: assert (ibus_adr == park_pc)
         else mismatch($sformatf("core fetches %h, expected the final loop at %h",
                                 ibus_adr, park_pc));
      $display("** PASS **");
      $finish;
   end

endmodule

//--- all.f
+incdir+.
serv_pkg.sv
serv_cnt_if.sv
serv_state.sv
serv_decode.sv
serv_alu.sv
serv_rf.sv
serv_ctrl.sv
serv_mem_if.sv
serv_top.sv
tb_serv_mem.sv
tb_serv.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core with its testbench in Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_serv -f all.f -o tb_serv_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_serv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
